// ==== verilog/md_bus_pkg.sv ====
/* Main-bus fabric shared definitions: widths, address map,
   FSM state codes and the bus word union */
package md_bus_pkg;

	// One bus word, either whole or as two byte lanes
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} b;
	} bus_word_u;

	// --------------------
	// Widths
	// --------------------
	localparam int WRAM_AW    = 15;
	localparam int ZRAM_AW    = 13;
	localparam int BANK_COUNT = 8;
	localparam int BANK_W     = 6;
	localparam int BAR_W      = 9;

	// Clock enable periods, in MCLK cycles
	localparam int Z80_CE_DIV     = 15;
	localparam int M68K_CE_DIV    = 7;
	localparam int M68K_CEN_PHASE = 3;

	// --------------------
	// 68K address map
	// --------------------
	localparam logic [3:0]  ROM_REGION_END = 4'hA;
	localparam logic [7:0]  ZBUS_REGION    = 8'hA0;
	localparam logic [11:0] CTRL_REGION    = 12'hA11;
	localparam logic [3:0]  BUSREQ_SEL     = 4'h1;
	localparam logic [3:0]  ZRESET_SEL     = 4'h2;
	localparam logic [19:0] BANKREG_REGION = 20'hA130F;
	localparam logic [2:0]  WRAM_REGION    = 3'b111;
	// Byte address, above which A130Fx switches ROM banks
	localparam logic [24:0] BIG_ROM_LIMIT  = 25'h200000;

	// Z80 address map
	localparam logic [6:0] Z80_BANK_PAGE = 7'h60;
	localparam int         Z80_WIN_BIT   = 15;

	// --------------------
	// Sequencer sources and states
	// --------------------
	localparam logic [1:0] MSRC_NONE = 2'd0;
	localparam logic [1:0] MSRC_M68K = 2'd1;
	localparam logic [1:0] MSRC_Z80  = 2'd2;

	localparam logic [2:0] MBUS_IDLE      = 3'd0;
	localparam logic [2:0] MBUS_SELECT    = 3'd1;
	localparam logic [2:0] MBUS_RAM_READ  = 3'd2;
	localparam logic [2:0] MBUS_ROM_READ  = 3'd3;
	localparam logic [2:0] MBUS_ZBUS_READ = 3'd4;
	localparam logic [2:0] MBUS_FINISH    = 3'd5;

	// Z-bus arbiter sources and states
	localparam logic ZSRC_MBUS = 1'b0;
	localparam logic ZSRC_Z80  = 1'b1;

	localparam logic [1:0] ZBUS_IDLE   = 2'd0;
	localparam logic [1:0] ZBUS_READ   = 2'd1;
	localparam logic [1:0] ZBUS_FINISH = 2'd2;

endpackage

// ==== verilog/bus_clock_enables.sv ====
/* Clock enables: 68K two-phase enables and the slower Z80 enable */
`timescale 1ns/1ps

module bus_clock_enables
	import md_bus_pkg::*;
(
	input  logic MCLK,
	input  logic reset,
	output logic m68k_cep,
	output logic m68k_cen,
	output logic z80_ce
);

	logic [$clog2(M68K_CE_DIV)-1:0] vcnt;
	logic [$clog2(Z80_CE_DIV)-1:0]  zcnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			vcnt <= '0;
			zcnt <= '0;
			m68k_cep <= 1'b0;
			m68k_cen <= 1'b0;
			z80_ce <= 1'b0;
		end else begin
			vcnt <= (vcnt == M68K_CE_DIV - 1) ? '0 : vcnt + 1'b1;
			zcnt <= (zcnt == Z80_CE_DIV - 1) ? '0 : zcnt + 1'b1;

			// Pulses line up with vcnt at 0 and at the phase value
			m68k_cep <= (vcnt == M68K_CE_DIV - 1);
			m68k_cen <= (vcnt == M68K_CEN_PHASE - 1);
			z80_ce <= (zcnt == Z80_CE_DIV - 1);
		end
	end

endmodule

// ==== verilog/open_bus_noise.sv ====
/* Open-bus noise: LFSR bits shifted into the floating bus word */
`timescale 1ns/1ps

module open_bus_noise
	import md_bus_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,
	input  logic      m68k_cep,
	output bus_word_u noise_word
);

	logic [16:0] lfsr;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			lfsr <= '0;
			noise_word <= '0;
		end else if (m68k_cep) begin
			// All-zero term lets the LFSR start from a cleared state
			lfsr <= {lfsr[0] ^ lfsr[2] ^ ~|lfsr, lfsr[16:1]};
			noise_word.word <= {noise_word.word[14:0], lfsr[0]};
		end
	end

endmodule

// ==== verilog/main_bus_sequencer.sv ====
/* Main-bus sequencer: arbitrates the 68K and Z80, decodes the map,
   holds the Z80 control and ROM bank registers */
`timescale 1ns/1ps

module main_bus_sequencer
	import md_bus_pkg::*;
(
	input  logic               MCLK,
	input  logic               reset,
	input  logic               m68k_cen,
	input  bus_word_u          noise_word,
	input  logic [23:1]        m68k_addr,
	input  logic [15:0]        m68k_wdata,
	output logic [15:0]        m68k_rdata,
	input  logic               m68k_as_n,
	input  logic               m68k_uds_n,
	input  logic               m68k_lds_n,
	input  logic               m68k_rnw,
	output logic               m68k_dtack_n,
	input  logic [15:0]        z80_addr,
	input  logic [7:0]         z80_wdata,
	input  logic               z80_mreq_n,
	input  logic               z80_rd_n,
	input  logic               z80_wr_n,
	output logic [7:0]         z80_mbus_data,
	output logic               z80_mbus_done_n,
	input  logic [BAR_W-1:0]   z80_bar,
	input  logic [24:1]        rom_size,
	output logic [24:1]        rom_addr,
	input  logic [15:0]        rom_data,
	output logic               rom_req,
	input  logic               rom_ack,
	output logic [WRAM_AW-1:0] wram_addr,
	output logic [15:0]        wram_wdata,
	output logic               wram_we_hi,
	output logic               wram_we_lo,
	input  logic [15:0]        wram_rdata,
	output logic               zbus_sel,
	output logic [14:0]        zbus_addr,
	output logic [7:0]         zbus_wdata,
	output logic               zbus_we,
	input  logic [7:0]         mbus_zbus_data,
	input  logic               mbus_zbus_ack_n,
	output logic               z80_busrq_n,
	output logic               z80_reset_n
);

	logic [2:0]        mstate;
	logic [1:0]        msrc;
	logic [23:1]       mbus_a;
	bus_word_u         mbus_do;
	bus_word_u         data;
	logic              mbus_rnw;
	logic              mbus_uds_n;
	logic              mbus_lds_n;
	logic [BANK_W-1:0] bank_reg [BANK_COUNT];
	logic              bank_on;
	logic              z80_io;
	logic              z80_zbus;
	logic              ctrl_sel;
	bus_word_u         ctrl_do;

	assign z80_io = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	// Direct Z-bus space, handled by the Z-bus controller
	assign z80_zbus = ~z80_addr[Z80_WIN_BIT] & ~&z80_addr[14:8];

	// --------------------
	// Target ports
	// --------------------
	// 512 KB ROM pages once banking is on
	assign rom_addr = bank_on ? {bank_reg[mbus_a[21:19]], mbus_a[18:1]} : {1'b0, mbus_a};

	assign wram_addr = mbus_a[WRAM_AW:1];
	assign wram_wdata = mbus_do.word;
	assign wram_we_hi = (mstate == MBUS_RAM_READ) & ~mbus_rnw & ~mbus_uds_n;
	assign wram_we_lo = (mstate == MBUS_RAM_READ) & ~mbus_rnw & ~mbus_lds_n;

	// Byte lane for the 8-bit Z bus
	assign zbus_addr = {mbus_a[14:1], mbus_uds_n};
	assign zbus_wdata = mbus_uds_n ? mbus_do.b.lo : mbus_do.b.hi;
	assign zbus_we = ~mbus_rnw;

	// Control page, bit 8 reads back the register, the rest floats
	assign ctrl_sel = (mbus_a[23:12] == CTRL_REGION) && (mbus_a[7:1] == 7'd0);

	always_comb begin
		ctrl_do = noise_word;
		if (mbus_a[11:8] == BUSREQ_SEL)
			ctrl_do.word[8] = z80_busrq_n;
		else if (mbus_a[11:8] == ZRESET_SEL)
			ctrl_do.word[8] = z80_reset_n;
	end

	// --------------------
	// Sequencer FSM
	// --------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate <= MBUS_IDLE;
			msrc <= MSRC_NONE;
			m68k_dtack_n <= 1'b1;
			z80_mbus_done_n <= 1'b1;
			zbus_sel <= 1'b0;
			rom_req <= 1'b0;
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
			bank_on <= 1'b0;
			for (int i = 0; i < BANK_COUNT; i++)
				bank_reg[i] <= BANK_W'(i);
		end else begin
			if (m68k_as_n)
				m68k_dtack_n <= 1'b1;
			if (!z80_io)
				z80_mbus_done_n <= 1'b1;

			case (mstate)
			MBUS_IDLE: begin
				// 68K first, on its second phase only
				if (!m68k_as_n && m68k_dtack_n && m68k_cen) begin
					msrc <= MSRC_M68K;
					mbus_a <= m68k_addr;
					mbus_do.word <= m68k_wdata;
					mbus_rnw <= m68k_rnw;
					mbus_uds_n <= m68k_uds_n;
					mbus_lds_n <= m68k_lds_n;
					data <= noise_word;
					mstate <= MBUS_SELECT;
				end else if (z80_io && !z80_zbus && z80_mbus_done_n) begin
					msrc <= MSRC_Z80;
					// Bank window, else the old VDP page, unmapped here
					mbus_a <= z80_addr[Z80_WIN_BIT] ? {z80_bar, z80_addr[14:1]}
						: {16'hC000, z80_addr[7:1]};
					mbus_do.word <= {z80_wdata, z80_wdata};
					mbus_rnw <= z80_wr_n;
					mbus_uds_n <= z80_addr[0];
					mbus_lds_n <= ~z80_addr[0];
					data.word <= 16'hFFFF;
					mstate <= MBUS_SELECT;
				end
			end

			MBUS_SELECT: begin
				// Unmapped finishes with the default data
				mstate <= MBUS_FINISH;
				if (mbus_a[23:20] < ROM_REGION_END) begin
					if (mbus_a < rom_size) begin
						rom_req <= ~rom_ack;
						mstate <= MBUS_ROM_READ;
					end
				end else if (mbus_a[23:16] == ZBUS_REGION) begin
					zbus_sel <= 1'b1;
					mstate <= MBUS_ZBUS_READ;
				end else if (ctrl_sel) begin
					data <= ctrl_do;
					if (!mbus_rnw && !mbus_uds_n) begin
						if (mbus_a[11:8] == BUSREQ_SEL)
							z80_busrq_n <= ~mbus_do.word[8];
						if (mbus_a[11:8] == ZRESET_SEL)
							z80_reset_n <= mbus_do.word[8];
					end
				end else if (mbus_a[23:4] == BANKREG_REGION) begin
					// Register 0 stays fixed
					if (!mbus_rnw && {rom_size, 1'b0} > BIG_ROM_LIMIT
						&& mbus_a[3:1] != 3'd0) begin
						bank_reg[mbus_a[3:1]] <= mbus_do.word[BANK_W-1:0];
						bank_on <= 1'b1;
					end
				end else if (mbus_a[23:21] == WRAM_REGION) begin
					mstate <= MBUS_RAM_READ;
				end
			end

			MBUS_RAM_READ: begin
				data.word <= wram_rdata;
				mstate <= MBUS_FINISH;
			end

			// Toggle handshake, stalls until the ROM side answers
			MBUS_ROM_READ: begin
				if (rom_req == rom_ack) begin
					data.word <= rom_data;
					mstate <= MBUS_FINISH;
				end
			end

			MBUS_ZBUS_READ: begin
				if (!mbus_zbus_ack_n) begin
					zbus_sel <= 1'b0;
					data.word <= {mbus_zbus_data, mbus_zbus_data};
					mstate <= MBUS_FINISH;
				end
			end

			MBUS_FINISH: begin
				if (msrc == MSRC_Z80) begin
					z80_mbus_data <= z80_addr[0] ? data.b.lo : data.b.hi;
					z80_mbus_done_n <= 1'b0;
					mstate <= MBUS_IDLE;
				end else begin
					m68k_rdata <= data.word;
					m68k_dtack_n <= 1'b0;
					if (m68k_as_n || mbus_rnw || !m68k_uds_n || !m68k_lds_n)
						mstate <= MBUS_IDLE;
				end
			end

			default: mstate <= MBUS_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/work_ram.sv ====
/* 68K work RAM: 32K words, one write enable per byte lane */
`timescale 1ns/1ps

module work_ram
	import md_bus_pkg::*;
(
	input  logic               MCLK,
	input  logic [WRAM_AW-1:0] wram_addr,
	input  logic [15:0]        wram_wdata,
	input  logic               wram_we_hi,
	input  logic               wram_we_lo,
	output logic [15:0]        wram_rdata
);

	logic [7:0] mem_hi [2**WRAM_AW];
	logic [7:0] mem_lo [2**WRAM_AW];

	// Read returns the old word during a write
	always_ff @(posedge MCLK) begin
		if (wram_we_hi)
			mem_hi[wram_addr] <= wram_wdata[15:8];
		if (wram_we_lo)
			mem_lo[wram_addr] <= wram_wdata[7:0];
		wram_rdata <= {mem_hi[wram_addr], mem_lo[wram_addr]};
	end

endmodule

// ==== verilog/z_bus_controller.sv ====
/* Z-bus controller: arbiter between main bus and Z80, with the
   8 KB Z80 RAM and the 9-bit bank register */
`timescale 1ns/1ps

module z_bus_controller
	import md_bus_pkg::*;
(
	input  logic             MCLK,
	input  logic             reset,
	input  logic             zbus_sel,
	input  logic [14:0]      zbus_addr,
	input  logic [7:0]       zbus_wdata,
	input  logic             zbus_we,
	output logic [7:0]       mbus_zbus_data,
	output logic             mbus_zbus_ack_n,
	input  logic             z80_busrq_n,
	input  logic             z80_reset_n,
	input  logic [15:0]      z80_addr,
	input  logic [7:0]       z80_wdata,
	input  logic             z80_mreq_n,
	input  logic             z80_rd_n,
	input  logic             z80_wr_n,
	output logic [7:0]       z80_zbus_data,
	output logic             z80_zbus_done_n,
	output logic [BAR_W-1:0] z80_bar
);

	logic [1:0]  zstate;
	logic        zsrc;
	logic [14:0] za;
	logic [7:0]  zdo;
	logic        zwe;
	logic [7:0]  zram [2**ZRAM_AW];
	logic [7:0]  zram_q;
	logic [7:0]  zbus_di;
	logic        zram_sel;
	logic        bank_sel;
	logic        zbus_free;
	logic        z80_zbus_sel;

	// Z80 access below 7F00 with A15 clear
	assign z80_zbus_sel = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n)
		& ~z80_addr[Z80_WIN_BIT] & ~&z80_addr[14:8];
	// Main bus owns the Z bus only when granted and out of reset
	assign zbus_free = ~z80_busrq_n & z80_reset_n;

	// RAM at 0000-1FFF, mirrored up to 3FFF
	assign zram_sel = ~za[14];
	assign bank_sel = (za[14:8] == Z80_BANK_PAGE);
	assign zbus_di = zram_sel ? zram_q : 8'hFF;

	always_ff @(posedge MCLK) begin
		if (zwe && zram_sel)
			zram[za[ZRAM_AW-1:0]] <= zdo;
		zram_q <= zram[za[ZRAM_AW-1:0]];
	end

	// --------------------
	// Bank register
	// --------------------
	// One bit per write, shifted in from the top
	always_ff @(posedge MCLK) begin
		if (reset)
			z80_bar <= '0;
		else if (bank_sel && zwe)
			z80_bar <= {zdo[0], z80_bar[BAR_W-1:1]};
	end

	// --------------------
	// Arbiter
	// --------------------
	always_ff @(posedge MCLK) begin
		zwe <= 1'b0;
		if (reset) begin
			zstate <= ZBUS_IDLE;
			mbus_zbus_ack_n <= 1'b1;
			z80_zbus_done_n <= 1'b1;
		end else begin
			if (!zbus_sel)
				mbus_zbus_ack_n <= 1'b1;
			if (!z80_zbus_sel)
				z80_zbus_done_n <= 1'b1;

			case (zstate)
			ZBUS_IDLE: begin
				if (zbus_sel && mbus_zbus_ack_n) begin
					za <= zbus_addr;
					zdo <= zbus_wdata;
					zwe <= zbus_we & zbus_free;
					zsrc <= ZSRC_MBUS;
					zstate <= ZBUS_READ;
				end else if (z80_zbus_sel && z80_zbus_done_n) begin
					za <= z80_addr[14:0];
					zdo <= z80_wdata;
					zwe <= ~z80_wr_n;
					zsrc <= ZSRC_Z80;
					zstate <= ZBUS_READ;
				end
			end

			// RAM read data settles here
			ZBUS_READ: zstate <= ZBUS_FINISH;

			ZBUS_FINISH: begin
				if (zsrc == ZSRC_MBUS) begin
					mbus_zbus_data <= zbus_free ? zbus_di : 8'hFF;
					mbus_zbus_ack_n <= 1'b0;
				end else begin
					z80_zbus_data <= zbus_di;
					z80_zbus_done_n <= 1'b0;
				end
				zstate <= ZBUS_IDLE;
			end

			default: zstate <= ZBUS_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/md_bus_top.sv ====
/* Main-bus fabric top: clock enables, sequencer, work RAM,
   Z-bus controller and noise source */
`timescale 1ns/1ps

module md_bus_top
	import md_bus_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,
	input  logic [23:1] m68k_addr,
	input  logic [15:0] m68k_wdata,
	input  logic        m68k_as_n,
	input  logic        m68k_uds_n,
	input  logic        m68k_lds_n,
	input  logic        m68k_rnw,
	output logic [15:0] m68k_rdata,
	output logic        m68k_dtack_n,
	input  logic [15:0] z80_addr,
	input  logic [7:0]  z80_wdata,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	output logic [7:0]  z80_rdata,
	output logic        z80_wait_n,
	output logic        m68k_cep,
	output logic        m68k_cen,
	output logic        z80_ce,
	output logic        z80_busrq_n,
	output logic        z80_reset_n,
	input  logic [24:1] rom_size,
	output logic [24:1] rom_addr,
	input  logic [15:0] rom_data,
	output logic        rom_req,
	input  logic        rom_ack
);

	bus_word_u          noise_word;
	logic [BAR_W-1:0]   z80_bar;
	logic [7:0]         z80_mbus_data;
	logic               z80_mbus_done_n;
	logic [7:0]         z80_zbus_data;
	logic               z80_zbus_done_n;
	logic [WRAM_AW-1:0] wram_addr;
	logic [15:0]        wram_wdata;
	logic               wram_we_hi;
	logic               wram_we_lo;
	logic [15:0]        wram_rdata;
	logic               zbus_sel;
	logic [14:0]        zbus_addr;
	logic [7:0]         zbus_wdata;
	logic               zbus_we;
	logic [7:0]         mbus_zbus_data;
	logic               mbus_zbus_ack_n;
	logic               z80_io;

	// Z80 data and wait merge from both paths
	assign z80_io = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_rdata = ~z80_zbus_done_n ? z80_zbus_data : z80_mbus_data;
	assign z80_wait_n = ~z80_mbus_done_n | ~z80_zbus_done_n | ~z80_io;

	bus_clock_enables u_bus_clock_enables (
		.MCLK     (MCLK),
		.reset    (reset),
		.m68k_cep (m68k_cep),
		.m68k_cen (m68k_cen),
		.z80_ce   (z80_ce)
	);

	open_bus_noise u_open_bus_noise (
		.MCLK       (MCLK),
		.reset      (reset),
		.m68k_cep   (m68k_cep),
		.noise_word (noise_word)
	);

	main_bus_sequencer u_main_bus_sequencer (
		.MCLK            (MCLK),
		.reset           (reset),
		.m68k_cen        (m68k_cen),
		.noise_word      (noise_word),
		.m68k_addr       (m68k_addr),
		.m68k_wdata      (m68k_wdata),
		.m68k_rdata      (m68k_rdata),
		.m68k_as_n       (m68k_as_n),
		.m68k_uds_n      (m68k_uds_n),
		.m68k_lds_n      (m68k_lds_n),
		.m68k_rnw        (m68k_rnw),
		.m68k_dtack_n    (m68k_dtack_n),
		.z80_addr        (z80_addr),
		.z80_wdata       (z80_wdata),
		.z80_mreq_n      (z80_mreq_n),
		.z80_rd_n        (z80_rd_n),
		.z80_wr_n        (z80_wr_n),
		.z80_mbus_data   (z80_mbus_data),
		.z80_mbus_done_n (z80_mbus_done_n),
		.z80_bar         (z80_bar),
		.rom_size        (rom_size),
		.rom_addr        (rom_addr),
		.rom_data        (rom_data),
		.rom_req         (rom_req),
		.rom_ack         (rom_ack),
		.wram_addr       (wram_addr),
		.wram_wdata      (wram_wdata),
		.wram_we_hi      (wram_we_hi),
		.wram_we_lo      (wram_we_lo),
		.wram_rdata      (wram_rdata),
		.zbus_sel        (zbus_sel),
		.zbus_addr       (zbus_addr),
		.zbus_wdata      (zbus_wdata),
		.zbus_we         (zbus_we),
		.mbus_zbus_data  (mbus_zbus_data),
		.mbus_zbus_ack_n (mbus_zbus_ack_n),
		.z80_busrq_n     (z80_busrq_n),
		.z80_reset_n     (z80_reset_n)
	);

	work_ram u_work_ram (
		.MCLK       (MCLK),
		.wram_addr  (wram_addr),
		.wram_wdata (wram_wdata),
		.wram_we_hi (wram_we_hi),
		.wram_we_lo (wram_we_lo),
		.wram_rdata (wram_rdata)
	);

	z_bus_controller u_z_bus_controller (
		.MCLK            (MCLK),
		.reset           (reset),
		.zbus_sel        (zbus_sel),
		.zbus_addr       (zbus_addr),
		.zbus_wdata      (zbus_wdata),
		.zbus_we         (zbus_we),
		.mbus_zbus_data  (mbus_zbus_data),
		.mbus_zbus_ack_n (mbus_zbus_ack_n),
		.z80_busrq_n     (z80_busrq_n),
		.z80_reset_n     (z80_reset_n),
		.z80_addr        (z80_addr),
		.z80_wdata       (z80_wdata),
		.z80_mreq_n      (z80_mreq_n),
		.z80_rd_n        (z80_rd_n),
		.z80_wr_n        (z80_wr_n),
		.z80_zbus_data   (z80_zbus_data),
		.z80_zbus_done_n (z80_zbus_done_n),
		.z80_bar         (z80_bar)
	);

endmodule

// ==== tests/md_bus_tb.sv ====
/* Bus fabric testbench: 68K and Z80 master models, a ROM responder
   with random latency, and checks of each bus path */
`timescale 1ns/1ps

module md_bus_tb;

	// Longest access is a ROM read of about 25 cycles, the whole run is well under 2000
	localparam int          TIMEOUT_CYCLES = 20000;
	localparam logic [31:0] LFSR_SEED      = 32'h1076_33dd;
	// Z80 bank that maps its window onto work RAM
	localparam int          Z80_BANK       = 32'hE00000 / 32'h8000;

	logic        MCLK;
	logic        reset;
	logic [23:1] m68k_addr;
	logic [15:0] m68k_wdata;
	logic        m68k_as_n;
	logic        m68k_uds_n;
	logic        m68k_lds_n;
	logic        m68k_rnw;
	logic [15:0] m68k_rdata;
	logic        m68k_dtack_n;
	logic [15:0] z80_addr;
	logic [7:0]  z80_wdata;
	logic        z80_mreq_n;
	logic        z80_rd_n;
	logic        z80_wr_n;
	logic [7:0]  z80_rdata;
	logic        z80_wait_n;
	logic        m68k_cep;
	logic        m68k_cen;
	logic        z80_ce;
	logic        z80_busrq_n;
	logic        z80_reset_n;
	logic [24:1] rom_size;
	logic [24:1] rom_addr;
	logic [15:0] rom_data;
	logic        rom_req;
	logic        rom_ack;

	int          checks;
	int          errors;
	int          cycle_count;
	logic [31:0] lfsr_state;
	logic [24:1] last_rom_addr;
	int          cep_age;
	int          zce_age;

	md_bus_top u_md_bus_top (.*);

	initial begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;
	end

	// --------------------
	// Helpers
	// --------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("error %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	// One 68K cycle, started on a second-phase enable
	task automatic m68k_access(input logic [23:0] addr, input logic rnw, input logic uds_n,
		input logic lds_n, input logic [15:0] wdata, output logic [15:0] rdata);
		@(posedge MCLK);
		while (!m68k_cen)
			@(posedge MCLK);
		#1;
		m68k_addr = addr[23:1];
		m68k_wdata = wdata;
		m68k_rnw = rnw;
		m68k_uds_n = uds_n;
		m68k_lds_n = lds_n;
		m68k_as_n = 1'b0;
		@(posedge MCLK);
		while (m68k_dtack_n)
			@(posedge MCLK);
		rdata = m68k_rdata;
		#1;
		m68k_as_n = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw = 1'b1;
		@(posedge MCLK);
		while (!m68k_dtack_n)
			@(posedge MCLK);
	endtask

	// Z80 strobes stay low until wait is released
	task automatic z80_access(input logic [15:0] addr, input logic wr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		@(posedge MCLK);
		#1;
		z80_addr = addr;
		z80_wdata = wdata;
		z80_mreq_n = 1'b0;
		z80_rd_n = wr;
		z80_wr_n = ~wr;
		@(posedge MCLK);
		while (!z80_wait_n)
			@(posedge MCLK);
		rdata = z80_rdata;
		#1;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		@(posedge MCLK);
	endtask

	// --------------------
	// ROM responder
	// --------------------
	initial begin : rom_responder
		int delay;

		rom_ack = 1'b0;
		rom_data = '0;
		lfsr_state = LFSR_SEED;
		forever begin
			@(posedge MCLK);
			if (!reset && rom_req !== rom_ack) begin
				last_rom_addr = rom_addr;
				delay = 0;
				for (int i = 0; i < 3; i++) begin
					lfsr_state = step_lfsr(lfsr_state);
					delay = (delay << 1) | int'(lfsr_state[0]);
				end
				repeat (delay) @(posedge MCLK);
				#1;
				rom_data = rom_addr[16:1] ^ 16'hA5A5;
				rom_ack = rom_req;
			end
		end
	end

	// --------------------
	// Clock enable spacing
	// --------------------
	// Cycles since the last pulse, -1 until the first one
	always @(posedge MCLK) begin
		if (reset) begin
			cep_age = -1;
			zce_age = -1;
		end else begin
			if (cep_age >= 0)
				cep_age++;
			if (zce_age >= 0)
				zce_age++;
			if (m68k_cen && cep_age >= 0) begin
				assert (cep_age == 3)
				else begin
					errors++;
					$display("m68k_cen fired %0d cycles after m68k_cep, not 3", cep_age);
				end
			end
			if (m68k_cep) begin
				if (cep_age >= 0) begin
					assert (cep_age == 7)
					else begin
						errors++;
						$display("m68k_cep repeated after %0d cycles, not 7", cep_age);
					end
				end
				cep_age = 0;
			end
			if (z80_ce) begin
				if (zce_age >= 0) begin
					assert (zce_age == 15)
					else begin
						errors++;
						$display("z80_ce repeated after %0d cycles, not 15", zce_age);
					end
				end
				zce_age = 0;
			end
		end
	end

	// dtack goes high the cycle after as_n is seen high
	assert property (@(posedge MCLK) disable iff (reset) $rose(m68k_as_n) |=> m68k_dtack_n)
	else begin
		errors++;
		$display("dtack_n did not rise one cycle after as_n was released");
	end

	assert property (@(posedge MCLK) disable iff (reset)
		(z80_mreq_n || (z80_rd_n && z80_wr_n)) |-> z80_wait_n)
	else begin
		errors++;
		$display("z80_wait_n was low while no Z80 access was active");
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge MCLK);
			cycle_count++;
		end
		$display("run did not finish within %0d cycles, a bus access hung", TIMEOUT_CYCLES);
		$display("checks %0d errors %0d", checks, errors + 1);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin : main_sequence
		logic [15:0] rd16;
		logic [7:0]  rd8;
		logic        req_start;
		logic        toggled;
		logic [15:0] merged;
		logic [31:0] exp_rom;

		checks = 0;
		errors = 0;
		reset = 1'b1;
		m68k_addr = '0;
		m68k_wdata = '0;
		m68k_as_n = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw = 1'b1;
		z80_addr = '0;
		z80_wdata = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		// 4 MB cartridge, as a word address
		rom_size = 24'h200000;
		repeat (4) @(posedge MCLK);
		#1 reset = 1'b0;

		// Outputs at rest
		@(posedge MCLK);
		check_value("reset dtack_n", 1, m68k_dtack_n);
		check_value("reset wait_n", 1, z80_wait_n);
		check_value("reset busrq_n", 1, z80_busrq_n);
		check_value("reset z80 reset_n", 0, z80_reset_n);
		check_value("reset cep", 0, m68k_cep);
		check_value("reset cen", 0, m68k_cen);
		check_value("reset z80 ce", 0, z80_ce);
		req_start = rom_req;
		toggled = 1'b0;
		repeat (50) begin
			@(posedge MCLK);
			if (rom_req !== req_start)
				toggled = 1'b1;
		end
		check_value("rom_req idle", 0, toggled);

		// Work RAM byte lanes
		m68k_access(24'hE01000, 1'b0, 1'b0, 1'b0, 16'h1234, rd16);
		m68k_access(24'hE01000, 1'b0, 1'b0, 1'b1, 16'hAB99, rd16);
		merged = {8'hAB, 8'h34};
		m68k_access(24'hE01000, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("wram merge", merged, rd16);

		// ROM, unbanked then bank 1 set to 5
		m68k_access(24'h080000, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("rom addr flat", 32'h080000, {last_rom_addr, 1'b0});
		check_value("rom data flat", (32'h080000 >> 1) & 32'hFFFF ^ 32'hA5A5, rd16);
		m68k_access(24'hA130F3, 1'b0, 1'b1, 1'b0, 16'h0005, rd16);
		exp_rom = 5 * 32'h80000 + (32'h081234 & 32'h7FFFF);
		m68k_access(24'h081234, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("rom addr banked", exp_rom, {last_rom_addr, 1'b0});
		check_value("rom data banked", (exp_rom >> 1) & 32'hFFFF ^ 32'hA5A5, rd16);

		// Z80 control registers
		m68k_access(24'hA11100, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("busreq read idle", 1, rd16[8]);
		m68k_access(24'hA11100, 1'b0, 1'b0, 1'b0, 16'h0100, rd16);
		check_value("busrq_n granted", 0, z80_busrq_n);
		m68k_access(24'hA11200, 1'b0, 1'b0, 1'b0, 16'h0100, rd16);
		check_value("z80 reset released", 1, z80_reset_n);
		m68k_access(24'hA11100, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("busreq read granted", 0, rd16[8]);

		// Z bus from the 68K, granted and not granted
		m68k_access(24'hA00020, 1'b0, 1'b0, 1'b1, 16'h5C00, rd16);
		m68k_access(24'hA00020, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("zbus granted read", 16'h5C5C, rd16);
		m68k_access(24'hA11100, 1'b0, 1'b0, 1'b0, 16'h0000, rd16);
		m68k_access(24'hA00020, 1'b0, 1'b0, 1'b1, 16'h3300, rd16);
		m68k_access(24'hA00020, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("zbus ungranted read", 16'hFFFF, rd16);
		m68k_access(24'hA11100, 1'b0, 1'b0, 1'b0, 16'h0100, rd16);
		m68k_access(24'hA00020, 1'b1, 1'b0, 1'b0, 16'h0000, rd16);
		check_value("zbus value kept", 16'h5C5C, rd16);

		// Z80 RAM and its mirror
		z80_access(16'h0123, 1'b1, 8'h96, rd8);
		z80_access(16'h2123, 1'b0, 8'h00, rd8);
		check_value("z80 ram mirror", 8'h96, rd8);

		// Bank register, one bit per write, low bit first
		for (int i = 0; i < 9; i++)
			z80_access(16'h6000, 1'b1, 8'((Z80_BANK >> i) & 1), rd8);
		z80_access(16'h9000, 1'b0, 8'h00, rd8);
		check_value("z80 window hi byte", merged[15:8], rd8);
		z80_access(16'h9001, 1'b0, 8'h00, rd8);
		check_value("z80 window lo byte", merged[7:0], rd8);

		z80_access(16'h7F10, 1'b0, 8'h00, rd8);
		check_value("z80 unmapped", 8'hFF, rd8);

		repeat (4) @(posedge MCLK);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/md_bus_pkg.sv
verilog/bus_clock_enables.sv
verilog/open_bus_noise.sv
verilog/main_bus_sequencer.sv
verilog/work_ram.sv
verilog/z_bus_controller.sv
verilog/md_bus_top.sv
tests/md_bus_tb.sv

// ==== Makefile ====
# Verilator build and run of the bus fabric testbench

obj_dir/Vmd_bus_tb: sim.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module md_bus_tb -f sim.f

.PHONY: run clean

run: obj_dir/Vmd_bus_tb
	@out="$$(./obj_dir/Vmd_bus_tb)"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
